//--- Makefile
# Verilator build and run for the complex correlator

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := corr_array_tb
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+include
design/corr_pkg.sv
design/srl_delay.sv
design/sipo_y.sv
design/pe_mac.sv
design/corr_array.sv
sim/corr_array_tb.sv

//--- design/corr_array.sv
`default_nettype none
`timescale 1ns/10ps

`include "corr_params.svh"

// Complex correlator with a Y loader feeding a row of MAC PEs
module corr_array (
    input  wire logic                                      clk,
    input  wire logic                                      rst,
    input  wire logic                                      ce,      // Global enable
    input  wire corr_pkg::y_word_t                         y_in,    // Serial Y stream
    input  wire corr_pkg::x_sample_t                       x_in,    // Broadcast X
    output logic                                           y_load,  // Load phase level
    output logic                                           res_v,   // Results valid pulse
    output logic [`CORR_PE_NUM*`CORR_ACC_WIDTH-1:0]        res_re,  // PE 0 in low slice
    output logic [`CORR_PE_NUM*`CORR_ACC_WIDTH-1:0]        res_im
);

    localparam int YW = 2 * `CORR_DATA_WIDTH;
    localparam int AW = `CORR_ACC_WIDTH;

    logic [`CORR_PE_NUM*YW-1:0] y_par;  // Tail words, one per PE
    logic proc_v;
    logic proc_first;
    logic proc_last;

    ////////////////////////////////////////////////////////////////////////////
    // Y loader
    ////////////////////////////////////////////////////////////////////////////

    sipo_y u_sipo (
        .clk        (clk),
        .rst        (rst),
        .ce         (ce),
        .y_in       (y_in),
        .y_load     (y_load),
        .y_par      (y_par),
        .proc_v     (proc_v),
        .proc_first (proc_first),
        .proc_last  (proc_last)
    );

    ////////////////////////////////////////////////////////////////////////////
    // PE row
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `CORR_PE_NUM; i++) begin : g_pe
        if (i == 0) begin : g_lead
            // PE 0 speaks for the row since all PEs share the strobes
            pe_mac u_pe (
                .clk        (clk),
                .rst        (rst),
                .ce         (ce),
                .x_in       (x_in),
                .y          (y_par[i*YW +: YW]),
                .proc_v     (proc_v),
                .proc_first (proc_first),
                .proc_last  (proc_last),
                .acc_re     (res_re[i*AW +: AW]),
                .acc_im     (res_im[i*AW +: AW]),
                .res_v      (res_v)
            );
        end else begin : g_rest
            pe_mac u_pe (
                .clk        (clk),
                .rst        (rst),
                .ce         (ce),
                .x_in       (x_in),
                .y          (y_par[i*YW +: YW]),
                .proc_v     (proc_v),
                .proc_first (proc_first),
                .proc_last  (proc_last),
                .acc_re     (res_re[i*AW +: AW]),
                .acc_im     (res_im[i*AW +: AW]),
                .res_v      ()
            );
        end
    end

endmodule

`default_nettype wire

//--- design/corr_pkg.sv
`default_nettype none

`include "corr_params.svh"

package corr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    // Complex Y word with real part in upper half and imaginary in lower
    typedef logic [2*`CORR_DATA_WIDTH-1:0] y_word_t;
    typedef logic signed [`CORR_DATA_WIDTH-1:0] x_sample_t;  // Real X sample
    typedef logic signed [`CORR_ACC_WIDTH-1:0] acc_t;        // One accumulator half

    // Frame sequencing counters
    typedef logic [`CORR_REG_ADDR_WIDTH-1:0] reg_cnt_t;  // Position in segment
    typedef logic [`CORR_PE_ADDR_WIDTH-1:0] pe_cnt_t;    // Segment index

    // Frame phase
    typedef enum logic {
        PH_LOAD = 1'b0,  // Chain fills from y_in
        PH_PROC = 1'b1   // Chain closed into a ring
    } phase_t;

endpackage

`default_nettype wire

//--- design/pe_mac.sv
`default_nettype none
`timescale 1ns/10ps

`include "corr_params.svh"

// Complex MAC of real X against complex Y over one process phase
module pe_mac (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                ce,
    input  wire corr_pkg::x_sample_t x_in,        // Broadcast real sample
    input  wire corr_pkg::y_word_t   y,           // Tail word of own segment
    input  wire logic                proc_v,      // Process phase level
    input  wire logic                proc_first,  // Restart the sums
    input  wire logic                proc_last,   // Capture the sums
    output corr_pkg::acc_t           acc_re,      // Finished real sum
    output corr_pkg::acc_t           acc_im,      // Finished imaginary sum
    output logic                     res_v        // One pulse per frame
);

    localparam int DW = `CORR_DATA_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // Products
    ////////////////////////////////////////////////////////////////////////////

    logic signed [DW-1:0]   y_re;     // Upper half of Y
    logic signed [DW-1:0]   y_im;     // Lower half of Y
    logic signed [2*DW-1:0] prod_re;  // Full 8x8 signed product
    logic signed [2*DW-1:0] prod_im;
    corr_pkg::acc_t         ext_re;   // Sign extended to sum width
    corr_pkg::acc_t         ext_im;

    assign y_re    = y[2*DW-1:DW];
    assign y_im    = y[DW-1:0];
    assign prod_re = x_in * y_re;
    assign prod_im = x_in * y_im;
    assign ext_re  = prod_re;  // Signed source sign extends
    assign ext_im  = prod_im;

    ////////////////////////////////////////////////////////////////////////////
    // Running sums
    ////////////////////////////////////////////////////////////////////////////

    corr_pkg::acc_t sum_re;
    corr_pkg::acc_t sum_im;
    corr_pkg::acc_t next_re;  // Sum including this cycle's product
    corr_pkg::acc_t next_im;

    // First cycle drops whatever the previous frame left
    assign next_re = proc_first ? ext_re : sum_re + ext_re;
    assign next_im = proc_first ? ext_im : sum_im + ext_im;

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_re <= '0;
            sum_im <= '0;
        end else if (ce && proc_v) begin
            sum_re <= next_re;
            sum_im <= next_im;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_re <= '0;
            acc_im <= '0;
            res_v  <= 1'b0;
        end else if (ce) begin
            res_v <= proc_last;  // Held through stalls until next enabled cycle
            if (proc_last) begin
                acc_re <= next_re;  // Includes the last product
                acc_im <= next_im;
            end
        end
    end

    // Pulses sit a frame apart and never touch
    a_res_v_single: assert property (@(posedge clk) disable iff (rst)
        (ce && res_v) |=> !res_v)
        else $error("res_v high in two consecutive enabled cycles");

endmodule

`default_nettype wire

//--- design/sipo_y.sv
`default_nettype none
`timescale 1ns/10ps

`include "corr_params.svh"

// Serial in, parallel out loader for the Y operand
// Load phase fills the chain and process phase rotates it as a ring
module sipo_y (
    input  wire logic                                      clk,
    input  wire logic                                      rst,
    input  wire logic                                      ce,
    input  wire corr_pkg::y_word_t                         y_in,
    output logic                                           y_load,      // Level, load phase
    output logic [`CORR_PE_NUM*2*`CORR_DATA_WIDTH-1:0]     y_par,       // Segment tails
    output logic                                           proc_v,      // Level, process phase
    output logic                                           proc_first,  // First process cycle
    output logic                                           proc_last    // Last process cycle
);

    localparam int YW = 2 * `CORR_DATA_WIDTH;  // Y word width

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////////////////////////////////////////

    corr_pkg::reg_cnt_t reg_cnt;  // Position within segment
    corr_pkg::pe_cnt_t  pe_cnt;   // Segment being filled or rotated
    corr_pkg::phase_t   phase;

    logic reg_last;  // Last position of a segment
    logic pe_last;   // Last segment
    logic frame_end; // Last cycle of the current phase

    assign reg_last  = (reg_cnt == '1);
    assign pe_last   = (pe_cnt == '1);
    assign frame_end = reg_last && pe_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_cnt <= '0;
            pe_cnt  <= '0;
            phase   <= corr_pkg::PH_LOAD;
        end else if (ce) begin
            reg_cnt <= reg_cnt + 1'b1;  // Wraps at REG_NUM
            if (reg_last) begin
                pe_cnt <= pe_cnt + 1'b1;  // Wraps at PE_NUM
            end
            if (frame_end) begin
                // Toggle between load and process
                phase <= (phase == corr_pkg::PH_LOAD) ? corr_pkg::PH_PROC
                                                      : corr_pkg::PH_LOAD;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Phase strobes decoded once for all PEs
    ////////////////////////////////////////////////////////////////////////////

    assign y_load     = (phase == corr_pkg::PH_LOAD);
    assign proc_v     = (phase == corr_pkg::PH_PROC);
    assign proc_first = proc_v && (reg_cnt == '0) && (pe_cnt == '0);
    assign proc_last  = proc_v && frame_end;

    ////////////////////////////////////////////////////////////////////////////
    // Segment chain
    ////////////////////////////////////////////////////////////////////////////

    corr_pkg::y_word_t seg_out [`CORR_PE_NUM];  // Tail of each segment
    corr_pkg::y_word_t head;                    // Chain input

    // Unregistered head mux keeps ring length equal to chain length
    assign head = y_load ? y_in : seg_out[`CORR_PE_NUM-1];

    for (genvar i = 0; i < `CORR_PE_NUM; i++) begin : g_seg
        corr_pkg::y_word_t seg_in;

        // Segment 0 takes the head and the rest chain low to high
        if (i == 0) begin : g_first
            assign seg_in = head;
        end else begin : g_next
            assign seg_in = seg_out[i-1];
        end

        srl_delay #(
            .DEPTH (`CORR_REG_NUM)
        ) u_srl (
            .clk  (clk),
            .ce   (ce),
            .din  (seg_in),
            .dout (seg_out[i])
        );

        assign y_par[i*YW +: YW] = seg_out[i];  // PE i sees tail of segment i
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Full load hands over to the first process cycle
    a_proc_opens: assert property (@(posedge clk) disable iff (rst)
        (ce && y_load && frame_end) |=> proc_first)
        else $error("process phase did not open with proc_first");

    // Last process cycle returns to a fresh load phase
    a_proc_closes: assert property (@(posedge clk) disable iff (rst)
        (ce && proc_last) |=> (y_load && (reg_cnt == '0) && (pe_cnt == '0)))
        else $error("load phase did not restart after proc_last");

    // Sequencer frozen while stalled
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        !ce |=> ($stable(phase) && $stable(reg_cnt) && $stable(pe_cnt)))
        else $error("sequencer moved while ce was low");

endmodule

`default_nettype wire

//--- design/srl_delay.sv
`default_nettype none
`timescale 1ns/10ps

`include "corr_params.svh"

// Y word delay line forming one segment of the loader chain
module srl_delay #(
    parameter int DEPTH = `CORR_REG_NUM  // Stages in this segment
) (
    input  wire logic              clk,
    input  wire logic              ce,    // Shift enable
    input  wire corr_pkg::y_word_t din,   // From head mux or previous segment
    output corr_pkg::y_word_t      dout   // Last stage
);

    // Shift stages, stage 0 nearest the input
    corr_pkg::y_word_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (ce) begin
            stage[0] <= din;  // New word enters at stage 0
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];  // Move one stage per enabled cycle
            end
        end
    end

    assign dout = stage[DEPTH-1];  // Tail of the segment

endmodule

`default_nettype wire

//--- include/corr_params.svh
`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

`define CORR_DATA_WIDTH 8        // X sample, and each half of a Y word
`define CORR_ACC_WIDTH 24        // Exact sum of 32 products of 8x8 signed

////////////////////////////////////////////////////////////////////////////
// Array geometry
////////////////////////////////////////////////////////////////////////////

`define CORR_PE_NUM 4            // Processing elements in the row
`define CORR_REG_NUM 8           // Stages per shift-register segment

// Counter widths as log2 of the two sizes above
`define CORR_REG_ADDR_WIDTH 3    // Position inside a segment
`define CORR_PE_ADDR_WIDTH 2     // Segment index

`endif

//--- sim/corr_array_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "corr_params.svh"

// Frame-level testbench for the complex correlator
module corr_array_tb;

    localparam int DW             = `CORR_DATA_WIDTH;
    localparam int AW             = `CORR_ACC_WIDTH;
    localparam int PE_NUM         = `CORR_PE_NUM;
    localparam int FRAME_LEN      = `CORR_PE_NUM * `CORR_REG_NUM;  // Enabled cycles per phase
    localparam int N_FRAMES       = 6;
    localparam int TIMEOUT_CYCLES = N_FRAMES * 64 * 3 + 100;
    localparam int DRAIN_SLOTS    = 40;  // Idle tail shorter than a frame

    // Data modes
    localparam int M_RAND = 0;
    localparam int M_MAXP = 1;  // 127 everywhere
    localparam int M_MAXN = 2;  // -128 everywhere
    localparam int M_RAMP = 3;  // Derived from word index

    ////////////////////////////////////////////////////////////////////////////
    // Frame table with one entry per frame applied back to back
    ////////////////////////////////////////////////////////////////////////////

    int tbl_y_mode [N_FRAMES] = '{M_RAND, M_RAND, M_MAXN, M_MAXN, M_RAMP, M_MAXP};
    int tbl_x_mode [N_FRAMES] = '{M_RAND, M_RAND, M_MAXN, M_MAXP, M_RAMP, M_RAND};
    int tbl_stall  [N_FRAMES] = '{0, 30, 0, 10, 0, 30};  // Percent of slots with ce low

    logic                          clk;
    logic                          rst;
    logic                          ce;
    corr_pkg::y_word_t             y_in;
    corr_pkg::x_sample_t           x_in;
    logic                          y_load;
    logic                          res_v;
    logic [PE_NUM*AW-1:0]          res_re;
    logic [PE_NUM*AW-1:0]          res_im;

    int seed = 32'h92fbd5c6;
    int cyc;              // Drive slots so far, one per rising edge
    int wd_cyc;           // Watchdog count
    int errors_mismatch;
    int errors_other;

    corr_pkg::y_word_t   ys [FRAME_LEN];  // Current frame stimulus
    corr_pkg::x_sample_t xs [FRAME_LEN];
    corr_pkg::acc_t      exp_re [PE_NUM];   // Model sums of the finished frame
    corr_pkg::acc_t      exp_im [PE_NUM];
    corr_pkg::acc_t      held_re [PE_NUM];  // Last published results
    corr_pkg::acc_t      held_im [PE_NUM];

    logic pending;       // Frame finished, pulse not seen yet
    int   pend_frame;
    int   pend_due;      // Exact pulse slot or -1 when stalls blur it
    logic prev_res_v;
    logic prev_ce;
    int   pulses [N_FRAMES];

    corr_array UUT (
        .clk    (clk),
        .rst    (rst),
        .ce     (ce),
        .y_in   (y_in),
        .x_in   (x_in),
        .y_load (y_load),
        .res_v  (res_v),
        .res_re (res_re),
        .res_im (res_im)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Watchdog
    initial begin
        for (wd_cyc = 0; wd_cyc < TIMEOUT_CYCLES; wd_cyc++) begin
            @(posedge clk);
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d mismatch, %0d other", errors_mismatch, errors_other + 1);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_acc(input string name, input corr_pkg::acc_t got,
                             input corr_pkg::acc_t expected);
        if (got !== expected) begin
            errors_mismatch++;
            $display("mismatch %s at cycle %0d: got %h expected %h", name, cyc, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            errors_mismatch++;
            $display("mismatch %s at cycle %0d: got %h expected %h", name, cyc, got, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Signed halves of a Y word
    function automatic int y_re_part(input corr_pkg::y_word_t w);
        logic signed [DW-1:0] b;
        b = w[2*DW-1:DW];
        return b;
    endfunction

    function automatic int y_im_part(input corr_pkg::y_word_t w);
        logic signed [DW-1:0] b;
        b = w[DW-1:0];
        return b;
    endfunction

    task automatic make_frame(input int f);
        int r;
        logic [DW-1:0] ramp;
        for (int n = 0; n < FRAME_LEN; n++) begin
            ramp = n[DW-1:0];
            r = $random(seed);
            case (tbl_y_mode[f])
                M_RAND:  ys[n] = r[2*DW-1:0];
                M_MAXP:  ys[n] = 16'h7f7f;
                M_MAXN:  ys[n] = 16'h8080;
                default: ys[n] = {ramp, -ramp};  // Re = n, Im = -n
            endcase
            r = $random(seed);
            case (tbl_x_mode[f])
                M_RAND:  xs[n] = r[DW-1:0];
                M_MAXP:  xs[n] = 8'h7f;
                M_MAXN:  xs[n] = 8'h80;
                default: xs[n] = ramp - 8'd16;  // Crosses zero mid-frame
            endcase
        end
    endtask

    // Rotation rule where PE i starts at word (PE_NUM-1-i)*REG_NUM
    task automatic model_sums();
        int k;
        int xv;
        int s_re;
        int s_im;
        for (int i = 0; i < PE_NUM; i++) begin
            s_re = 0;
            s_im = 0;
            for (int t = 0; t < FRAME_LEN; t++) begin
                k = ((PE_NUM - 1 - i) * `CORR_REG_NUM + t) % FRAME_LEN;
                xv = xs[t];  // Sign extends
                s_re += xv * y_re_part(ys[k]);
                s_im += xv * y_im_part(ys[k]);
            end
            exp_re[i] = s_re[AW-1:0];
            exp_im[i] = s_im[AW-1:0];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_slot();
        @(posedge clk);
        cyc++;
        #1;  // Outputs settled and inputs change here
    endtask

    task automatic drive_inputs(input logic en, input corr_pkg::y_word_t y,
                                input corr_pkg::x_sample_t x);
        ce      = en;
        y_in    = y;
        x_in    = x;
        prev_ce = en;
    endtask

    task automatic sample_outputs();
        logic new_pulse;
        corr_pkg::acc_t got_re;
        corr_pkg::acc_t got_im;
        // A pulse held over a stall is the same pulse
        new_pulse = res_v && !(prev_res_v && !prev_ce);
        if (pending && pend_due == cyc) begin
            check_bit("res_v", res_v, 1'b1);
        end
        if (new_pulse) begin
            if (!pending) begin
                errors_other++;
                $display("ERROR: result pulse at cycle %0d with no finished frame", cyc);
            end else begin
                if (pend_due >= 0 && cyc != pend_due) begin
                    errors_other++;
                    $display("ERROR: frame %0d result pulse at cycle %0d, due at cycle %0d",
                             pend_frame, cyc, pend_due);
                end
                for (int i = 0; i < PE_NUM; i++) begin
                    got_re = res_re[i*AW +: AW];
                    got_im = res_im[i*AW +: AW];
                    check_acc($sformatf("res_re[%0d]", i), got_re, exp_re[i]);
                    check_acc($sformatf("res_im[%0d]", i), got_im, exp_im[i]);
                    held_re[i] = exp_re[i];
                    held_im[i] = exp_im[i];
                end
                pulses[pend_frame]++;
                pending = 1'b0;
            end
        end else begin
            // Between pulses the results must not move
            for (int i = 0; i < PE_NUM; i++) begin
                got_re = res_re[i*AW +: AW];
                got_im = res_im[i*AW +: AW];
                check_acc($sformatf("res_re[%0d] hold", i), got_re, held_re[i]);
                check_acc($sformatf("res_im[%0d] hold", i), got_im, held_im[i]);
            end
        end
        prev_res_v = res_v;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int ld;          // Enabled load cycles so far
        int pr;          // Enabled process cycles so far
        int first_slot;  // Slot of the first enabled load cycle
        int r;
        logic en;

        rst  = 1'b1;
        ce   = 1'b0;
        y_in = '0;
        x_in = '0;
        cyc  = 0;
        errors_mismatch = 0;
        errors_other    = 0;
        pending    = 1'b0;
        pend_frame = 0;
        pend_due   = -1;
        prev_res_v = 1'b0;
        prev_ce    = 1'b0;
        for (int i = 0; i < PE_NUM; i++) begin
            held_re[i] = '0;
            held_im[i] = '0;
        end
        for (int f = 0; f < N_FRAMES; f++) begin
            pulses[f] = 0;
        end

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("y_load", y_load, 1'b1);  // Starts in load phase
        check_bit("res_v", res_v, 1'b0);

        for (int f = 0; f < N_FRAMES; f++) begin
            make_frame(f);
            ld = 0;
            pr = 0;
            first_slot = -1;
            while (ld < FRAME_LEN || pr < FRAME_LEN) begin
                next_slot();
                sample_outputs();
                check_bit("y_load", y_load, ld < FRAME_LEN);
                r  = $random(seed);
                en = ((r & 32'h7fffffff) % 100) >= tbl_stall[f];
                if (y_load && ld < FRAME_LEN) begin
                    drive_inputs(en, ys[ld], '0);  // Y only matters in load
                    if (en) begin
                        if (first_slot < 0) begin
                            first_slot = cyc;
                        end
                        ld++;
                    end
                end else if (!y_load && pr < FRAME_LEN) begin
                    drive_inputs(en, '0, xs[pr]);  // X only matters in process
                    if (en) begin
                        pr++;
                    end
                end else begin
                    drive_inputs(1'b1, '0, '0);  // Out of step so let the DUT move on
                end
            end
            model_sums();
            pending    = 1'b1;
            pend_frame = f;
            // Without stalls the pulse lands two phases after the first load
            pend_due   = (tbl_stall[f] == 0) ? first_slot + 2 * FRAME_LEN : -1;
        end

        // Collect the last pulse, then watch for stray ones
        while (pending) begin
            next_slot();
            sample_outputs();
            drive_inputs(1'b1, '0, '0);
        end
        repeat (DRAIN_SLOTS) begin
            next_slot();
            sample_outputs();
            drive_inputs(1'b1, '0, '0);
        end

        for (int f = 0; f < N_FRAMES; f++) begin
            if (pulses[f] != 1) begin
                errors_other++;
                $display("ERROR: frame %0d gave %0d result pulses instead of one", f, pulses[f]);
            end
        end

        $display("errors: %0d mismatch, %0d other", errors_mismatch, errors_other);
        if (errors_mismatch + errors_other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
